// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module ahb_matrix_tb -o ahb_matrix_sim
	./obj_dir/ahb_matrix_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+verilog
verilog/ahb_matrix_pkg.sv
verilog/ahb_matrix_interconnect.sv
verilog/ahb_ram_slave.sv
verilog/ahb_ram_busy.sv
verilog/ahb_gpio_slave.sv
verilog/ahb_matrix.sv
verification/ahb_matrix_properties.sv
verification/ahb_matrix_tb.sv

// ==== verification/ahb_matrix_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module ahb_matrix_properties (
    input wire                      HCLK,
    input wire                      HRESETn,
    input wire                      HREADY,
    input wire                      HRESP,
    input wire                      gpio_sel,  // address-phase select of the gpio
    input ahb_matrix_pkg::htrans_t  HTRANS,
    input ahb_matrix_pkg::led_t     leds
);

    logic [3:0] low_cnt;      // consecutive cycles with HREADY low
    logic       gpio_accept;

    assign gpio_accept = gpio_sel && HTRANS[1];

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            low_cnt <= '0;
        end else if (!HREADY) begin
            low_cnt <= low_cnt + 4'd1;
        end else begin
            low_cnt <= '0;
        end
    end

    ready_after_reset: assert property (@(posedge HCLK) $rose(HRESETn) |-> HREADY)
        else $error("HREADY low in the first cycle after reset");

    resp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn) !HRESP)
        else $error("HRESP went high");

    // at most the configured number of wait states in a row
    wait_bounded: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !HREADY |-> (low_cnt < 4'(`AHB_BUSY_WAIT_CYCLES)))
        else $error("HREADY low for too many cycles");

    // address phase, data phase, then the new value is visible
    leds_after_gpio: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $changed(leds) |-> $past(gpio_accept, 2))
        else $error("leds changed without a gpio write");

endmodule

bind ahb_matrix ahb_matrix_properties properties_i (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .HREADY   (HREADY),
    .HRESP    (HRESP),
    .gpio_sel (hsel[`AHB_DEV_GPIO]),
    .HTRANS   (HTRANS),
    .leds     (leds)
);

`default_nettype wire

// ==== verification/ahb_matrix_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module ahb_matrix_tb;

    localparam int                     TIMEOUT = 50;  // cycles per wait
    localparam ahb_matrix_pkg::hsize_t SZ_BYTE = 3'd0;
    localparam ahb_matrix_pkg::hsize_t SZ_HALF = 3'd1;
    localparam ahb_matrix_pkg::hsize_t SZ_WORD = 3'd2;

    localparam logic [1:0] CHK_NONE = 2'd0;
    localparam logic [1:0] CHK_DATA = 2'd1;  // compare HRDATA in the data phase
    localparam logic [1:0] CHK_LEDS = 2'd2;  // compare leds after the data phase

    typedef struct packed {
        logic                     write;
        ahb_matrix_pkg::haddr_t   addr;
        ahb_matrix_pkg::hsize_t   size;
        ahb_matrix_pkg::hdata_t   wdata;
        ahb_matrix_pkg::switch_t  sw;
        logic                     b2b;    // address phase overlaps previous data phase
        logic [1:0]               chk;
        ahb_matrix_pkg::hdata_t   exp;    // read data or leds in the low half
    } xfer_t;

    logic                     HCLK;
    logic                     HRESETn;
    ahb_matrix_pkg::haddr_t   HADDR;
    ahb_matrix_pkg::htrans_t  HTRANS;
    ahb_matrix_pkg::hsize_t   HSIZE;
    logic                     HWRITE;
    ahb_matrix_pkg::hdata_t   HWDATA;
    ahb_matrix_pkg::hdata_t   HRDATA;
    logic                     HREADY;
    logic                     HRESP;
    ahb_matrix_pkg::led_t     leds;
    ahb_matrix_pkg::switch_t  switches;

    xfer_t                    table_q [$];
    ahb_matrix_pkg::hdata_t   ref_mem [ahb_matrix_pkg::haddr_t];  // keyed by word address
    ahb_matrix_pkg::led_t     ref_leds;
    int                       errors;
    logic                     timed_out;

    ahb_matrix ahb_matrix_i (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .HADDR    (HADDR),
        .HTRANS   (HTRANS),
        .HSIZE    (HSIZE),
        .HWRITE   (HWRITE),
        .HWDATA   (HWDATA),
        .HRDATA   (HRDATA),
        .HREADY   (HREADY),
        .HRESP    (HRESP),
        .leds     (leds),
        .switches (switches)
    );

    always #10 HCLK = ~HCLK;

    // --------------------
    // reference model
    // --------------------

    // copy the written bytes that the size and offset cover
    function automatic ahb_matrix_pkg::hdata_t merge_lanes(
        input ahb_matrix_pkg::hdata_t old,
        input ahb_matrix_pkg::hdata_t wdata,
        input ahb_matrix_pkg::hsize_t size,
        input logic [1:0]             ofs
    );
        ahb_matrix_pkg::hdata_t res;
        logic                   hit;
        res = old;
        for (int i = 0; i < 4; i++) begin
            case (size)
                SZ_BYTE: hit = (2'(i) == ofs);
                SZ_HALF: hit = ((i >= 2) == ofs[1]);
                default: hit = 1'b1;
            endcase
            if (hit) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic add_xfer(input logic write, input ahb_matrix_pkg::haddr_t addr,
                            input ahb_matrix_pkg::hsize_t size,
                            input ahb_matrix_pkg::hdata_t wdata,
                            input ahb_matrix_pkg::switch_t sw, input logic b2b);
        xfer_t                  x;
        ahb_matrix_pkg::haddr_t key;
        logic                   is_ram;
        logic                   is_gpio;
        key     = {addr[31:2], 2'b00};
        is_ram  = (addr[31:28] == `AHB_RAM_MATCH) || (addr[31:28] == `AHB_BUSY_MATCH);
        is_gpio = (addr[31:12] == `AHB_GPIO_MATCH);
        x       = '{write, addr, size, wdata, sw, b2b, CHK_NONE, 32'h0};
        if (write && is_ram) begin
            ref_mem[key] = merge_lanes(ref_mem.exists(key) ? ref_mem[key] : '0,
                                       wdata, size, addr[1:0]);
        end else if (write && is_gpio && addr[11:0] == 12'h000) begin
            ref_leds = wdata[15:0];
            x.chk    = CHK_LEDS;
            x.exp    = {16'h0000, ref_leds};
        end else if (!write) begin
            x.chk = CHK_DATA;  // unmapped and gpio holes stay zero
            if (is_ram) begin
                x.exp = ref_mem[key];
            end else if (is_gpio && addr[11:0] == 12'h000) begin
                x.exp = {16'h0000, ref_leds};
            end else if (is_gpio && addr[11:0] == 12'h004) begin
                x.exp = {24'h000000, sw};
            end
        end
        table_q.push_back(x);
    endtask

    // --------------------
    // bus driver and checks
    // --------------------

    task automatic drive_addr(input xfer_t x);
        HADDR  = x.addr;
        HTRANS = 2'b10;  // NONSEQ
        HSIZE  = x.size;
        HWRITE = x.write;
    endtask

    // returns at a falling edge with HREADY high so the next rising edge ends the phase
    task automatic wait_ready(output logic saw_low);
        int cycles;
        saw_low = 1'b0;
        cycles  = 0;
        while (!HREADY && cycles < TIMEOUT) begin
            saw_low = 1'b1;
            @(negedge HCLK);
            cycles++;
        end
        if (!HREADY) begin
            $display("timeout: HREADY stayed low for %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_data(input string name, input ahb_matrix_pkg::hdata_t got,
                              input ahb_matrix_pkg::hdata_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_leds(input string name, input ahb_matrix_pkg::led_t got,
                              input ahb_matrix_pkg::led_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%04h expected 0x%04h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%01h expected 0x%01h", name, got, exp);
            errors++;
        end
    endtask

    initial begin
        xfer_t cur;
        logic  saw_low;
        int    errors_before;
        HCLK      = 1'b0;
        HRESETn   = 1'b0;
        HADDR     = '0;
        HTRANS    = 2'b00;
        HSIZE     = SZ_WORD;
        HWRITE    = 1'b0;
        HWDATA    = '0;
        switches  = '0;
        errors    = 0;
        timed_out = 1'b0;
        ref_leds  = '0;
        void'($urandom(32'h3e0c_4993));

        // word write and read back in the fast RAM
        add_xfer(1'b1, 32'h0000_0010, SZ_WORD, $urandom(), 8'h00, 1'b0);
        add_xfer(1'b0, 32'h0000_0010, SZ_WORD, '0, 8'h00, 1'b0);
        // byte lanes merged into a known word
        add_xfer(1'b1, 32'h0000_0020, SZ_WORD, $urandom(), 8'h00, 1'b0);
        for (int i = 0; i < 4; i++) begin
            add_xfer(1'b1, 32'h0000_0020 + i, SZ_BYTE, $urandom(), 8'h00, 1'b0);
            add_xfer(1'b0, 32'h0000_0020, SZ_WORD, '0, 8'h00, 1'b0);
        end
        add_xfer(1'b1, 32'h0000_0024, SZ_WORD, $urandom(), 8'h00, 1'b0);
        add_xfer(1'b1, 32'h0000_0026, SZ_HALF, $urandom(), 8'h00, 1'b0);
        add_xfer(1'b1, 32'h0000_0024, SZ_HALF, $urandom(), 8'h00, 1'b0);
        add_xfer(1'b0, 32'h0000_0024, SZ_WORD, '0, 8'h00, 1'b0);
        // wait-state RAM
        add_xfer(1'b1, 32'h2000_0040, SZ_WORD, $urandom(), 8'h00, 1'b0);
        add_xfer(1'b0, 32'h2000_0040, SZ_WORD, '0, 8'h00, 1'b0);
        add_xfer(1'b1, 32'h2000_0042, SZ_HALF, $urandom(), 8'h00, 1'b0);
        add_xfer(1'b0, 32'h2000_0040, SZ_WORD, '0, 8'h00, 1'b0);
        // gpio leds and switches
        add_xfer(1'b1, 32'h4000_0000, SZ_WORD, $urandom(), 8'h00, 1'b0);
        add_xfer(1'b0, 32'h4000_0000, SZ_WORD, '0, 8'h00, 1'b0);
        add_xfer(1'b0, 32'h4000_0004, SZ_WORD, '0, 8'ha5, 1'b0);
        // unmapped reads return zero and unmapped writes leave the RAM word at 0x10 alone
        add_xfer(1'b0, 32'h1000_0000, SZ_WORD, '0, 8'ha5, 1'b0);
        add_xfer(1'b1, 32'h1000_0010, SZ_WORD, $urandom(), 8'ha5, 1'b0);
        add_xfer(1'b0, 32'h0000_0010, SZ_WORD, '0, 8'ha5, 1'b0);
        // back to back write then read in both RAMs
        add_xfer(1'b1, 32'h0000_0080, SZ_WORD, $urandom(), 8'ha5, 1'b0);
        add_xfer(1'b0, 32'h0000_0080, SZ_WORD, '0, 8'ha5, 1'b1);
        add_xfer(1'b1, 32'h2000_0084, SZ_WORD, $urandom(), 8'ha5, 1'b0);
        add_xfer(1'b0, 32'h2000_0084, SZ_WORD, '0, 8'ha5, 1'b1);

        repeat (3) @(negedge HCLK);
        HRESETn = 1'b1;
        @(negedge HCLK);

        for (int n = 0; n < table_q.size() && !timed_out; n++) begin
            cur           = table_q[n];
            errors_before = errors;
            if (!cur.b2b) begin
                if (cur.sw != switches) begin
                    switches = cur.sw;
                    repeat (4) @(negedge HCLK);  // through the synchronizer
                end
                drive_addr(cur);
                wait_ready(saw_low);
                @(negedge HCLK);
            end
            // data phase of cur overlapping any back to back address phase
            HWDATA = cur.wdata;
            if (n + 1 < table_q.size() && table_q[n+1].b2b) begin
                drive_addr(table_q[n+1]);
            end else begin
                HTRANS = 2'b00;
            end
            wait_ready(saw_low);
            if (!timed_out) begin
                if (cur.chk == CHK_DATA) begin
                    check_data("HRDATA", HRDATA, cur.exp);
                end
                check_resp("HRESP", HRESP, 1'b0);
                if (cur.addr[31:28] == `AHB_BUSY_MATCH && !saw_low) begin
                    $display("wait-state RAM transfer finished without a wait state");
                    errors++;
                end
                @(negedge HCLK);
                if (cur.chk == CHK_LEDS) begin
                    check_leds("leds", leds, cur.exp[15:0]);
                end
                $display("test %0d %s addr 0x%08h: %s", n, cur.write ? "write" : "read",
                         cur.addr, (errors == errors_before) ? "ok" : "FAIL");
            end
        end

        $display("%0d transfers, %0d errors", table_q.size(), errors);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/ahb_gpio_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_gpio_slave (
    input  wire                     HCLK,
    input  wire                     HRESETn,
    input  wire                     HSEL,
    input  ahb_matrix_pkg::haddr_t  HADDR,
    input  ahb_matrix_pkg::htrans_t HTRANS,
    input  wire                     HWRITE,
    input  ahb_matrix_pkg::hdata_t  HWDATA,
    input  ahb_matrix_pkg::switch_t switches,
    output ahb_matrix_pkg::hdata_t  HRDATA,
    output logic                    hready_out,
    output logic                    HRESP,
    output ahb_matrix_pkg::led_t    leds
);

    localparam logic [9:0] REG_LED    = 10'd0;  // offset 0x0
    localparam logic [9:0] REG_SWITCH = 10'd1;  // offset 0x4

    logic                     accept;
    logic [9:0]               reg_r;     // word offset within the 4 KB window
    logic                     write_r;
    ahb_matrix_pkg::switch_t  sw_meta;
    ahb_matrix_pkg::switch_t  sw_sync;

    assign accept = HSEL && HTRANS[1];

    // --------------------
    // bus side
    // --------------------

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            write_r <= 1'b0;
        end else begin
            write_r <= accept && HWRITE;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            reg_r <= HADDR[11:2];
        end
    end

    // led register, written at the end of the data phase
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            leds <= '0;
        end else if (write_r && reg_r == REG_LED) begin
            leds <= HWDATA[15:0];
        end
    end

    // two-flop synchronizer for the asynchronous switches
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            sw_meta <= '0;
            sw_sync <= '0;
        end else begin
            sw_meta <= switches;
            sw_sync <= sw_meta;
        end
    end

    always_comb begin
        case (reg_r)
            REG_LED:    HRDATA = {16'h0000, leds};
            REG_SWITCH: HRDATA = {24'h000000, sw_sync};
            default:    HRDATA = '0;  // holes read zero
        endcase
    end

    assign hready_out = 1'b1;
    assign HRESP      = 1'b0;

endmodule

`default_nettype wire

// ==== verilog/ahb_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module ahb_matrix (
    input  wire                     HCLK,
    input  wire                     HRESETn,
    input  ahb_matrix_pkg::haddr_t  HADDR,
    input  ahb_matrix_pkg::htrans_t HTRANS,
    input  ahb_matrix_pkg::hsize_t  HSIZE,
    input  wire                     HWRITE,
    input  ahb_matrix_pkg::hdata_t  HWDATA,
    output ahb_matrix_pkg::hdata_t  HRDATA,
    output logic                    HREADY,
    output logic                    HRESP,
    output ahb_matrix_pkg::led_t    leds,
    input  ahb_matrix_pkg::switch_t switches
);

    ahb_matrix_pkg::hsel_t   hsel;       // address-phase selects
    ahb_matrix_pkg::hsel_t   ready_vec;
    ahb_matrix_pkg::hsel_t   resp_vec;
    ahb_matrix_pkg::hdata_t  rdata_ram;
    ahb_matrix_pkg::hdata_t  rdata_busy;
    ahb_matrix_pkg::hdata_t  rdata_gpio;

    // --------------------
    // interconnect
    // --------------------

    ahb_matrix_interconnect interconnect_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HADDR      (HADDR),
        .ready_vec  (ready_vec),
        .rdata_ram  (rdata_ram),
        .rdata_busy (rdata_busy),
        .rdata_gpio (rdata_gpio),
        .resp_vec   (resp_vec),
        .hsel       (hsel),
        .HREADY     (HREADY),
        .HRDATA     (HRDATA),
        .HRESP      (HRESP)
    );

    // --------------------
    // slaves
    // --------------------

    ahb_ram_slave #(
        .ADDR_WIDTH (`AHB_RAM_ADDR_WIDTH)
    ) ram_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HSEL       (hsel[`AHB_DEV_RAM]),
        .HADDR      (HADDR),
        .HTRANS     (HTRANS),
        .HSIZE      (HSIZE),
        .HWRITE     (HWRITE),
        .HWDATA     (HWDATA),
        .HRDATA     (rdata_ram),
        .hready_out (ready_vec[`AHB_DEV_RAM]),
        .HRESP      (resp_vec[`AHB_DEV_RAM])
    );

    ahb_ram_busy #(
        .ADDR_WIDTH  (`AHB_RAM_ADDR_WIDTH),
        .WAIT_CYCLES (`AHB_BUSY_WAIT_CYCLES)
    ) busy_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HSEL       (hsel[`AHB_DEV_BUSY]),
        .HADDR      (HADDR),
        .HTRANS     (HTRANS),
        .HSIZE      (HSIZE),
        .HWRITE     (HWRITE),
        .HWDATA     (HWDATA),
        .HRDATA     (rdata_busy),
        .hready_out (ready_vec[`AHB_DEV_BUSY]),
        .HRESP      (resp_vec[`AHB_DEV_BUSY])
    );

    ahb_gpio_slave gpio_i (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HSEL       (hsel[`AHB_DEV_GPIO]),
        .HADDR      (HADDR),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HWDATA     (HWDATA),
        .switches   (switches),
        .HRDATA     (rdata_gpio),
        .hready_out (ready_vec[`AHB_DEV_GPIO]),
        .HRESP      (resp_vec[`AHB_DEV_GPIO]),
        .leds       (leds)
    );

endmodule

`default_nettype wire

// ==== verilog/ahb_matrix_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module ahb_matrix_interconnect (
    input  wire                     HCLK,
    input  wire                     HRESETn,
    input  ahb_matrix_pkg::haddr_t  HADDR,
    input  ahb_matrix_pkg::hsel_t   ready_vec,
    input  ahb_matrix_pkg::hdata_t  rdata_ram,
    input  ahb_matrix_pkg::hdata_t  rdata_busy,
    input  ahb_matrix_pkg::hdata_t  rdata_gpio,
    input  ahb_matrix_pkg::hsel_t   resp_vec,
    output ahb_matrix_pkg::hsel_t   hsel,
    output logic                    HREADY,
    output ahb_matrix_pkg::hdata_t  HRDATA,
    output logic                    HRESP
);

    ahb_matrix_pkg::hsel_t addr_sel;  // decoded from the current address
    ahb_matrix_pkg::hsel_t data_sel;  // device owning the data phase

    // --------------------
    // address decode
    // --------------------

    assign addr_sel[`AHB_DEV_RAM]  = (HADDR[31:28] == `AHB_RAM_MATCH);
    assign addr_sel[`AHB_DEV_BUSY] = (HADDR[31:28] == `AHB_BUSY_MATCH);
    assign addr_sel[`AHB_DEV_GPIO] = (HADDR[31:12] == `AHB_GPIO_MATCH);

    // --------------------
    // selection
    // --------------------

    // a slave only ends its data phase when every slave is ready
    assign HREADY = &ready_vec;

    // address-phase select is held low while stalled
    assign hsel = HREADY ? addr_sel : '0;

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            data_sel <= '0;
        end else if (HREADY) begin
            data_sel <= hsel;  // empty when unmapped
        end
    end

    // --------------------
    // response mux
    // --------------------

    always_comb begin
        HRDATA = '0;  // unmapped reads return zero
        if (data_sel[`AHB_DEV_RAM]) begin
            HRDATA = rdata_ram;
        end else if (data_sel[`AHB_DEV_BUSY]) begin
            HRDATA = rdata_busy;
        end else if (data_sel[`AHB_DEV_GPIO]) begin
            HRDATA = rdata_gpio;
        end
    end

    // only the owner of the data phase may flag a response
    assign HRESP = |(resp_vec & data_sel);

endmodule

`default_nettype wire

// ==== verilog/ahb_matrix_params.svh ====
`ifndef AHB_MATRIX_PARAMS_SVH
`define AHB_MATRIX_PARAMS_SVH

// --------------------
// device map
// --------------------

`define AHB_DEVICE_COUNT      3

`define AHB_DEV_RAM           0
`define AHB_DEV_BUSY          1
`define AHB_DEV_GPIO          2

// region match values
`define AHB_RAM_MATCH         4'h0      // HADDR[31:28]
`define AHB_BUSY_MATCH        4'h2      // HADDR[31:28]
`define AHB_GPIO_MATCH        20'h40000 // HADDR[31:12]

// --------------------
// slave sizing
// --------------------

`define AHB_RAM_ADDR_WIDTH    10        // word address, 4 KB
`define AHB_BUSY_WAIT_CYCLES  2

`endif

// ==== verilog/ahb_matrix_pkg.sv ====
`default_nettype none

`include "ahb_matrix_params.svh"

package ahb_matrix_pkg;

    typedef logic [31:0]                    haddr_t;
    typedef logic [31:0]                    hdata_t;
    typedef logic [`AHB_DEVICE_COUNT-1:0]   hsel_t;  // one-hot, one bit per slave
    typedef logic [1:0]                     htrans_t;
    typedef logic [2:0]                     hsize_t;
    typedef logic [3:0]                     strobe_t;
    typedef logic [15:0]                    led_t;
    typedef logic [7:0]                     switch_t;

    // wait-state RAM data phase
    typedef enum logic [1:0] {
        BUSY_IDLE,
        BUSY_WAIT,   // hready_out held low
        BUSY_LAST    // final cycle of the data phase
    } busy_state_t;

    // byte lanes touched by a transfer of the given size and offset
    function automatic strobe_t byte_strobe(input hsize_t size, input logic [1:0] offset);
        case (size)
            3'b000:  byte_strobe = strobe_t'(4'b0001 << offset);
            3'b001:  byte_strobe = offset[1] ? 4'b1100 : 4'b0011;
            default: byte_strobe = 4'b1111;  // word and anything wider
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/ahb_ram_busy.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module ahb_ram_busy #(
    parameter int ADDR_WIDTH  = `AHB_RAM_ADDR_WIDTH,
    parameter int WAIT_CYCLES = `AHB_BUSY_WAIT_CYCLES  // 1 or more
) (
    input  wire                     HCLK,
    input  wire                     HRESETn,
    input  wire                     HSEL,
    input  ahb_matrix_pkg::haddr_t  HADDR,
    input  ahb_matrix_pkg::htrans_t HTRANS,
    input  ahb_matrix_pkg::hsize_t  HSIZE,
    input  wire                     HWRITE,
    input  ahb_matrix_pkg::hdata_t  HWDATA,
    output ahb_matrix_pkg::hdata_t  HRDATA,
    output logic                    hready_out,
    output logic                    HRESP
);

    localparam int DEPTH     = 2 ** ADDR_WIDTH;
    localparam int CNT_WIDTH = $clog2(WAIT_CYCLES + 1);

    ahb_matrix_pkg::hdata_t       mem [DEPTH];

    ahb_matrix_pkg::busy_state_t  state;
    logic [CNT_WIDTH-1:0]         wait_cnt;  // wait cycles left minus one
    logic                         accept;
    logic [ADDR_WIDTH-1:0]        addr_r;
    logic                         write_r;
    ahb_matrix_pkg::strobe_t      strobe_r;

    assign accept = HSEL && HTRANS[1];

    // --------------------
    // wait-state FSM
    // --------------------

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state    <= ahb_matrix_pkg::BUSY_IDLE;
            wait_cnt <= '0;
            write_r  <= 1'b0;
        end else begin
            case (state)
                ahb_matrix_pkg::BUSY_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= ahb_matrix_pkg::BUSY_LAST;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                default: begin
                    // idle, or last cycle overlapping the next address phase
                    if (accept) begin
                        state    <= ahb_matrix_pkg::BUSY_WAIT;
                        wait_cnt <= CNT_WIDTH'(WAIT_CYCLES - 1);
                        write_r  <= HWRITE;
                    end else begin
                        state    <= ahb_matrix_pkg::BUSY_IDLE;
                        write_r  <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            addr_r   <= HADDR[ADDR_WIDTH+1:2];
            strobe_r <= ahb_matrix_pkg::byte_strobe(HSIZE, HADDR[1:0]);
        end
    end

    // --------------------
    // array access
    // --------------------

    always_ff @(posedge HCLK) begin
        if (state == ahb_matrix_pkg::BUSY_LAST && write_r) begin
            for (int i = 0; i < 4; i++) begin
                if (strobe_r[i]) begin
                    mem[addr_r][8*i +: 8] <= HWDATA[8*i +: 8];
                end
            end
        end
    end

    assign HRDATA = mem[addr_r];

    // low only while counting, so no path back from HSEL
    assign hready_out = (state != ahb_matrix_pkg::BUSY_WAIT);
    assign HRESP      = 1'b0;

endmodule

`default_nettype wire

// ==== verilog/ahb_ram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module ahb_ram_slave #(
    parameter int ADDR_WIDTH = `AHB_RAM_ADDR_WIDTH
) (
    input  wire                     HCLK,
    input  wire                     HRESETn,
    input  wire                     HSEL,
    input  ahb_matrix_pkg::haddr_t  HADDR,
    input  ahb_matrix_pkg::htrans_t HTRANS,
    input  ahb_matrix_pkg::hsize_t  HSIZE,
    input  wire                     HWRITE,
    input  ahb_matrix_pkg::hdata_t  HWDATA,
    output ahb_matrix_pkg::hdata_t  HRDATA,
    output logic                    hready_out,
    output logic                    HRESP
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    ahb_matrix_pkg::hdata_t   mem [DEPTH];

    logic                     accept;
    logic [ADDR_WIDTH-1:0]    addr_r;    // word address of the data phase
    logic                     write_r;
    ahb_matrix_pkg::strobe_t  strobe_r;

    // NONSEQ or SEQ, HSEL already carries HREADY
    assign accept = HSEL && HTRANS[1];

    // --------------------
    // address phase
    // --------------------

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            write_r <= 1'b0;
        end else begin
            write_r <= accept && HWRITE;  // data phase is exactly one cycle
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            addr_r   <= HADDR[ADDR_WIDTH+1:2];
            strobe_r <= ahb_matrix_pkg::byte_strobe(HSIZE, HADDR[1:0]);
        end
    end

    // --------------------
    // data phase
    // --------------------

    // enabled lanes land on the edge that closes the data phase
    always_ff @(posedge HCLK) begin
        if (write_r) begin
            for (int i = 0; i < 4; i++) begin
                if (strobe_r[i]) begin
                    mem[addr_r][8*i +: 8] <= HWDATA[8*i +: 8];
                end
            end
        end
    end

    // array read at the registered address, sees the previous write
    assign HRDATA = mem[addr_r];

    assign hready_out = 1'b1;  // zero wait states
    assign HRESP      = 1'b0;  // always OKAY

endmodule

`default_nettype wire
